// ==== dv/lsu_checker.sv ====
`default_nettype none

module lsu_checker
  import lsu_bus_pkg::*;
(
  input wire          clock,
  input wire          reset,
  input wire rd_req_t rd_req_i,
  input wire wr_req_t wr_req_i,
  input wire          arready_i,
  input wire          awready_i,
  input wire          wready_i,
  input wire          out_valid_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // a valid may only drop after its ready
  ar_held: assert property (@(posedge clock) disable iff (reset)
    rd_req_i.arvalid && !arready_i |=> rd_req_i.arvalid)
    else $error("arvalid dropped before arready");

  aw_held: assert property (@(posedge clock) disable iff (reset)
    wr_req_i.awvalid && !awready_i |=> wr_req_i.awvalid)
    else $error("awvalid dropped before awready");

  w_held: assert property (@(posedge clock) disable iff (reset)
    wr_req_i.wvalid && !wready_i |=> wr_req_i.wvalid)
    else $error("wvalid dropped before wready");

  // responder accepts address and data together
  aw_w_paired: assert property (@(posedge clock) disable iff (reset)
    (wr_req_i.awvalid || wr_req_i.wvalid) |-> (wr_req_i.awvalid == wr_req_i.wvalid))
    else $error("awvalid and wvalid differ during a store");

  quiet_in_reset: assert property (@(posedge clock) reset |=> !out_valid_i)
    else $error("out_valid_o high during reset");

endmodule

bind lsu_top lsu_checker lsu_checker_i (
  .clock       (clock),
  .reset       (reset),
  .rd_req_i    (rd_req_o),
  .wr_req_i    (wr_req_o),
  .arready_i   (arready_i),
  .awready_i   (awready_i),
  .wready_i    (wready_i),
  .out_valid_i (out_valid_o)
);

`default_nettype wire

// ==== dv/lsu_tb.sv ====
`default_nettype none

module lsu_tb
  import lsu_pkg::*;
  import lsu_bus_pkg::*;
;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_entries = 23;
  localparam int timeout_ns  = (num_entries * 40 + 10) * 10;

  typedef struct packed {
    lsu_req_t    req;
    logic [31:0] wd;
    logic [7:0]  wstrb;
    logic [63:0] wdata;
  } entry_t;

  logic     clock;
  logic     reset;
  logic     in_valid;
  lsu_req_t in_req;
  logic     in_ready;
  rd_req_t  rd_req;
  logic     rready;
  logic     arready;
  logic     rvalid;
  beat_u    rdata;
  wr_req_t  wr_req;
  logic     awready;
  logic     wready;
  logic     out_valid;
  wb_t      wb;

  entry_t      table_q[$];
  int          wr_q[$];
  int          rd_q[$];
  int          out_idx;
  int          errors;
  int          failed_tests;
  int          stall_cnt;
  logic [31:0] rng;
  logic [1:0]  ar_cnt;
  logic [1:0]  aw_cnt;
  logic [1:0]  r_cnt;
  logic        rd_pend;
  logic [31:0] raddr;

  lsu_top lsu_top_i (
    .clock       (clock),
    .reset       (reset),
    .in_valid_i  (in_valid),
    .in_req_i    (in_req),
    .in_ready_o  (in_ready),
    .rd_req_o    (rd_req),
    .rready_o    (rready),
    .arready_i   (arready),
    .rvalid_i    (rvalid),
    .rdata_i     (rdata),
    .wr_req_o    (wr_req),
    .awready_i   (awready),
    .wready_i    (wready),
    .out_valid_o (out_valid),
    .wb_o        (wb)
  );

  always #5 clock = ~clock;

  function automatic logic [1:0] rand_delay();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng[1:0];
  endfunction

  // memory byte at address a holds a[7:0] + 8'h5a
  function automatic beat_u read_beat(input logic [31:0] a);
    beat_u b;
    for (int k = 0; k < 8; k++) begin
      b.bytes[k] = {a[7:3], 3'b000} + 8'(k) + 8'h5a;
    end
    return b;
  endfunction

  task automatic check_field(input string name, input logic [63:0] got,
                             input logic [63:0] exp, inout int bad);
    assert (got === exp) else begin
      $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
      errors++;
      bad++;
    end
  endtask

  task automatic add_entry(input logic ld, input logic st, input logic sgn,
                           input logic [1:0] sz, input logic [31:0] addr,
                           input logic [31:0] sdata, input logic [31:0] src2,
                           input wd_sel_e sel, input logic [31:0] wd,
                           input logic [7:0] wstrb, input logic [63:0] wdata);
    entry_t e;
    e.req.addr_or_result = addr;
    e.req.pc             = 32'h1000 + 32'(4 * table_q.size());
    e.req.src2           = src2;
    e.req.store_data     = sdata;
    e.req.load_mask      = (sz == 2'd0) ? 32'h0000_00ff :
                           (sz == 2'd1) ? 32'h0000_ffff : 32'hffff_ffff;
    e.req.store_mask     = (sz == 2'd0) ? 8'h01 : (sz == 2'd1) ? 8'h03 : 8'h0f;
    e.req.load_en        = ld;
    e.req.store_en       = st;
    e.req.is_signed      = sgn;
    e.req.wd_sel         = sel;
    e.req.rd             = 5'(table_q.size() + 1);
    e.req.reg_en         = !st;
    e.wd                 = wd;
    e.wstrb              = wstrb;
    e.wdata              = wdata;
    table_q.push_back(e);
  endtask

  // memory responder with random ready delays
  always @(negedge clock) begin
    int bad;
    entry_t e;
    if (reset) begin
      arready <= 1'b0;
      awready <= 1'b0;
      wready  <= 1'b0;
      rvalid  <= 1'b0;
      rd_pend <= 1'b0;
      ar_cnt  <= rand_delay();
      aw_cnt  <= rand_delay();
    end else begin
      bad = 0;
      if (!rd_req.arvalid) begin
        arready <= 1'b0;
        ar_cnt  <= rand_delay();
      end else if (!arready) begin
        if (ar_cnt == 2'd0) begin
          arready <= 1'b1;
          rd_pend <= 1'b1;
          r_cnt   <= rand_delay();
          raddr   <= rd_req.araddr;
          if (rd_q.size() == 0) begin
            $display("a read was issued with no load pending");
            errors++;
          end else begin
            e = table_q[rd_q.pop_front()];
            check_field("araddr", 64'(rd_req.araddr), 64'(e.req.addr_or_result), bad);
          end
        end else begin
          ar_cnt <= ar_cnt - 2'd1;
        end
      end
      if (rvalid) begin
        check_field("rready_o", 64'(rready), 64'(1), bad);
        rvalid  <= 1'b0;
        rd_pend <= 1'b0;
      end else if (rd_pend && !arready) begin
        if (r_cnt == 2'd0) begin
          rvalid <= 1'b1;
          rdata  <= read_beat(raddr);
        end else begin
          r_cnt <= r_cnt - 2'd1;
        end
      end
      if (!wr_req.awvalid) begin
        awready <= 1'b0;
        wready  <= 1'b0;
        aw_cnt  <= rand_delay();
      end else if (!awready) begin
        if (aw_cnt == 2'd0) begin
          awready <= 1'b1;
          wready  <= 1'b1;
          if (wr_q.size() == 0) begin
            $display("a write was issued with no store pending");
            errors++;
          end else begin
            e = table_q[wr_q.pop_front()];
            check_field("awaddr", 64'(wr_req.awaddr), 64'(e.req.addr_or_result), bad);
            check_field("wstrb", 64'(wr_req.wstrb), 64'(e.wstrb), bad);
            check_field("wdata", wr_req.wdata, e.wdata, bad);
          end
        end else begin
          aw_cnt <= aw_cnt - 2'd1;
        end
      end
    end
  end

  // every write-back pulse against the next table entry
  always @(negedge clock) begin
    int bad;
    entry_t e;
    if (!reset && out_valid) begin
      bad = 0;
      if (out_idx >= table_q.size()) begin
        $display("a write-back record arrived after the last entry");
        errors++;
      end else begin
        e = table_q[out_idx];
        check_field("wb_o.wd", 64'(wb.wd), 64'(e.wd), bad);
        check_field("wb_o.pc", 64'(wb.pc), 64'(e.req.pc), bad);
        check_field("wb_o.rd", 64'(wb.rd), 64'(e.req.rd), bad);
        check_field("wb_o.reg_en", 64'(wb.reg_en), 64'(e.req.reg_en), bad);
        if (bad != 0) begin
          failed_tests++;
        end
        $display("test %0d pc %h: %s", out_idx, e.req.pc, (bad == 0) ? "ok" : "mismatch");
      end
      out_idx++;
    end
  end

  initial begin
    #(timeout_ns);
    $display("timeout: only %0d of %0d records arrived", out_idx, num_entries);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    int bad;
    clock = 1'b0;
    reset = 1'b1;
    in_valid = 1'b0;
    in_req = '0;
    arready = 1'b0;
    rvalid = 1'b0;
    rdata = '0;
    awready = 1'b0;
    wready = 1'b0;
    rng = 32'h9431223c;
    out_idx = 0;
    errors = 0;
    failed_tests = 0;
    stall_cnt = 0;
    bad = 0;

    // word loads at both lanes
    add_entry(1, 0, 0, 2'd2, 32'h100, 0, 0, wd_load, 32'h5d5c5b5a, 0, 0);
    add_entry(1, 0, 0, 2'd2, 32'h104, 0, 0, wd_load, 32'h61605f5e, 0, 0);
    // byte and half loads, signed and unsigned
    add_entry(1, 0, 1, 2'd0, 32'h1a5, 0, 0, wd_load, 32'hffffffff, 0, 0);
    add_entry(1, 0, 0, 2'd0, 32'h1a5, 0, 0, wd_load, 32'h000000ff, 0, 0);
    add_entry(1, 0, 1, 2'd0, 32'h113, 0, 0, wd_load, 32'h0000006d, 0, 0);
    add_entry(1, 0, 1, 2'd1, 32'h1a2, 0, 0, wd_load, 32'hfffffdfc, 0, 0);
    add_entry(1, 0, 0, 2'd1, 32'h1a2, 0, 0, wd_load, 32'h0000fdfc, 0, 0);
    add_entry(1, 0, 1, 2'd1, 32'h20c, 0, 0, wd_load, 32'h00006766, 0, 0);
    // stores
    add_entry(0, 1, 0, 2'd0, 32'h303, 32'h123456ab, 0, wd_alu, 32'h303,
              8'h08, 64'h00000000_ab000000);
    add_entry(0, 1, 0, 2'd1, 32'h306, 32'h0000beef, 32'h77, wd_src2, 32'h77,
              8'hc0, 64'hbeef0000_00000000);
    add_entry(0, 1, 0, 2'd2, 32'h30c, 32'hcafef00d, 0, wd_alu, 32'h30c,
              8'hf0, 64'hcafef00d_00000000);
    add_entry(0, 1, 0, 2'd2, 32'h310, 32'h01020304, 0, wd_alu, 32'h310,
              8'h0f, 64'h00000000_01020304);
    // no memory access
    add_entry(0, 0, 0, 2'd2, 32'hdeadbeef, 0, 0, wd_alu, 32'hdeadbeef, 0, 0);
    add_entry(0, 0, 0, 2'd2, 32'h0, 0, 0, wd_link, 32'h1038, 0, 0);
    add_entry(0, 0, 0, 2'd2, 32'h0, 0, 32'h55aa, wd_src2, 32'h55aa, 0, 0);
    add_entry(1, 0, 0, 2'd0, 32'h1a6, 0, 0, wd_load, 32'h00000000, 0, 0);
    // remaining byte and half offsets
    add_entry(1, 0, 1, 2'd0, 32'h1a0, 0, 0, wd_load, 32'hfffffffa, 0, 0);
    add_entry(1, 0, 0, 2'd0, 32'h1a1, 0, 0, wd_load, 32'h000000fb, 0, 0);
    add_entry(1, 0, 1, 2'd0, 32'h1a2, 0, 0, wd_load, 32'hfffffffc, 0, 0);
    add_entry(1, 0, 0, 2'd0, 32'h1a4, 0, 0, wd_load, 32'h000000fe, 0, 0);
    add_entry(1, 0, 1, 2'd0, 32'h1a7, 0, 0, wd_load, 32'h00000001, 0, 0);
    add_entry(1, 0, 1, 2'd1, 32'h1a0, 0, 0, wd_load, 32'hfffffbfa, 0, 0);
    add_entry(1, 0, 1, 2'd1, 32'h19e, 0, 0, wd_load, 32'hfffff9f8, 0, 0);

    repeat (3) @(posedge clock);
    @(negedge clock);
    check_field("rready_o", 64'(rready), 64'(0), bad);
    reset = 1'b0;
    @(negedge clock);
    check_field("out_valid_o", 64'(out_valid), 64'(0), bad);
    check_field("arvalid", 64'(rd_req.arvalid), 64'(0), bad);
    check_field("awvalid", 64'(wr_req.awvalid), 64'(0), bad);
    check_field("wvalid", 64'(wr_req.wvalid), 64'(0), bad);
    check_field("rready_o", 64'(rready), 64'(1), bad);
    check_field("in_ready_o", 64'(in_ready), 64'(1), bad);

    // back to back, stalls only on in_ready_o
    for (int i = 0; i < table_q.size(); i++) begin
      in_valid = 1'b1;
      in_req = table_q[i].req;
      while (!in_ready) begin
        stall_cnt++;
        @(negedge clock);
      end
      @(posedge clock);
      if (table_q[i].req.store_en) begin
        wr_q.push_back(i);
      end
      if (table_q[i].req.load_en) begin
        rd_q.push_back(i);
      end
      @(negedge clock);
    end
    in_valid = 1'b0;

    wait (out_idx == num_entries);
    repeat (4) @(negedge clock);
    assert (stall_cnt > 0) else begin
      $display("in_ready_o never dropped while the buffer was full");
      errors++;
    end
    assert (wr_q.size() == 0) else begin
      $display("%0d stores never issued a write", wr_q.size());
      errors++;
    end
    assert (rd_q.size() == 0) else begin
      $display("%0d loads never issued a read", rd_q.size());
      errors++;
    end
    $display("tests %0d, failed %0d, errors %0d", out_idx, failed_tests, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/lsu_bus_pkg.sv ====
`default_nettype none

package lsu_bus_pkg;

  localparam int addr_w = 32;
  localparam int beat_w = 64;
  localparam int strb_w = 8;

  // one read beat, decoded as two 32-bit lanes or as eight bytes
  typedef union packed {
    logic [1:0][31:0] words;
    logic [7:0][7:0]  bytes;
  } beat_u;

  // read address channel
  typedef struct packed {
    logic [addr_w-1:0] araddr;
    logic              arvalid;
  } rd_req_t;

  // write address and write data channels
  typedef struct packed {
    logic [addr_w-1:0] awaddr;
    logic [beat_w-1:0] wdata;
    logic [strb_w-1:0] wstrb;
    logic              awvalid;
    logic              wvalid;
  } wr_req_t;

endpackage

`default_nettype wire

// ==== logic/lsu_decode.sv ====
`default_nettype none

module lsu_decode
  import lsu_pkg::*;
(
  input  wire            clock,
  input  wire            reset,
  input  wire            in_valid_i,
  input  wire lsu_req_t  in_req_i,
  output logic           in_ready_o,
  input  wire            acc_take_i,
  output logic           acc_valid_o,
  output access_t        acc_o
);

  lsu_req_t buf_q;
  logic     buf_valid;
  lsu_req_t req;
  logic     park;

  // live request arrives but execute is busy
  assign park = in_valid_i && !buf_valid && !acc_take_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      buf_valid <= 1'b0;
    end else if (buf_valid && acc_take_i) begin
      buf_valid <= 1'b0;
    end else if (park) begin
      buf_valid <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (park) begin
      buf_q <= in_req_i;
    end
  end

  // buffered entry is older, so it goes first
  assign req         = buf_valid ? buf_q : in_req_i;
  assign acc_valid_o = buf_valid || in_valid_i;
  assign in_ready_o  = !buf_valid;

  always_comb begin
    acc_o.kind       = kind_none;
    acc_o.size       = size_word;
    acc_o.is_signed  = req.is_signed;
    acc_o.addr       = req.addr_or_result;
    acc_o.store_data = req.store_data;
    acc_o.pc         = req.pc;
    acc_o.src2       = req.src2;
    acc_o.wd_sel     = req.wd_sel;
    acc_o.rd         = req.rd;
    acc_o.reg_en     = req.reg_en;
    if (req.load_en) begin
      acc_o.kind = kind_load;
      case (req.load_mask)
        mask_byte: acc_o.size = size_byte;
        mask_half: acc_o.size = size_half;
        mask_word: acc_o.size = size_word;
        default:   acc_o.kind = kind_none;
      endcase
    end else if (req.store_en) begin
      acc_o.kind = kind_store;
      case (req.store_mask)
        strb_byte: acc_o.size = size_byte;
        strb_half: acc_o.size = size_half;
        strb_word: acc_o.size = size_word;
        default:   acc_o.kind = kind_none;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/lsu_execute.sv ====
`default_nettype none

module lsu_execute
  import lsu_pkg::*;
  import lsu_bus_pkg::*;
(
  input  wire            clock,
  input  wire            reset,
  input  wire            acc_valid_i,
  input  wire access_t   acc_i,
  output logic           acc_take_o,
  output rd_req_t        rd_req_o,
  output logic           rready_o,
  input  wire            arready_i,
  input  wire            rvalid_i,
  input  wire beat_u     rdata_i,
  output wr_req_t        wr_req_o,
  input  wire            awready_i,
  input  wire            wready_i,
  output logic           done_valid_o,
  output access_t        done_o,
  output beat_u          beat_o
);

  typedef enum logic [2:0] {
    st_idle,
    st_raddr,
    st_rdata,
    st_write,
    st_done
  } state_e;

  state_e            state;
  access_t           acc_r;
  access_t           done_r;
  beat_u             beat_r;
  logic              arvalid_r;
  logic              awvalid_r;
  logic              wvalid_r;
  logic              rready_r;
  logic              done_valid_r;
  logic              aw_fin;
  logic              w_fin;
  logic [beat_w-1:0] wdata;
  logic [strb_w-1:0] wstrb;

  lsu_store_align store_align_i (
    .addr_i  (acc_r.addr),
    .size_i  (acc_r.size),
    .data_i  (acc_r.store_data),
    .wdata_o (wdata),
    .wstrb_o (wstrb)
  );

  assign acc_take_o = (state == st_idle);

  // channel already accepted, or accepted this cycle
  assign aw_fin = !awvalid_r || awready_i;
  assign w_fin  = !wvalid_r || wready_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      state        <= st_idle;
      arvalid_r    <= 1'b0;
      awvalid_r    <= 1'b0;
      wvalid_r     <= 1'b0;
      rready_r     <= 1'b0;
      done_valid_r <= 1'b0;
    end else begin
      rready_r     <= 1'b1;
      done_valid_r <= 1'b0;
      case (state)
        st_idle: begin
          if (acc_valid_i) begin
            case (acc_i.kind)
              kind_load: begin
                arvalid_r <= 1'b1;
                state     <= st_raddr;
              end
              kind_store: begin
                awvalid_r <= 1'b1;
                wvalid_r  <= 1'b1;
                state     <= st_write;
              end
              default: state <= st_done;
            endcase
          end
        end
        st_raddr: begin
          if (arready_i) begin
            arvalid_r <= 1'b0;
            state     <= st_rdata;
          end
        end
        st_rdata: begin
          if (rvalid_i && rready_r) begin
            state <= st_done;
          end
        end
        st_write: begin
          // each channel drops on its own handshake
          if (awready_i) begin
            awvalid_r <= 1'b0;
          end
          if (wready_i) begin
            wvalid_r <= 1'b0;
          end
          if (aw_fin && w_fin) begin
            state <= st_done;
          end
        end
        st_done: begin
          done_valid_r <= 1'b1;
          state        <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == st_idle && acc_valid_i) begin
      acc_r <= acc_i;
    end
    if (state == st_rdata && rvalid_i && rready_r) begin
      beat_r <= rdata_i;
    end
    // acc_r may be reloaded while the pulse is out
    if (state == st_done) begin
      done_r <= acc_r;
    end
  end

  assign rd_req_o.araddr  = acc_r.addr;
  assign rd_req_o.arvalid = arvalid_r;
  assign rready_o         = rready_r;

  assign wr_req_o.awaddr  = acc_r.addr;
  assign wr_req_o.wdata   = wdata;
  assign wr_req_o.wstrb   = wstrb;
  assign wr_req_o.awvalid = awvalid_r;
  assign wr_req_o.wvalid  = wvalid_r;

  assign done_valid_o = done_valid_r;
  assign done_o       = done_r;
  assign beat_o       = beat_r;

endmodule

`default_nettype wire

// ==== logic/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  // legal load masks
  localparam logic [xlen-1:0] mask_byte = 32'h0000_00ff;
  localparam logic [xlen-1:0] mask_half = 32'h0000_ffff;
  localparam logic [xlen-1:0] mask_word = 32'hffff_ffff;

  // legal store masks
  localparam logic [7:0] strb_byte = 8'h01;
  localparam logic [7:0] strb_half = 8'h03;
  localparam logic [7:0] strb_word = 8'h0f;

  typedef enum logic [1:0] {
    wd_alu  = 2'd0,
    wd_load = 2'd1,
    wd_link = 2'd2,
    wd_src2 = 2'd3
  } wd_sel_e;

  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } size_e;

  typedef enum logic [1:0] {
    kind_none  = 2'd0,
    kind_load  = 2'd1,
    kind_store = 2'd2
  } kind_e;

  // request as it comes from execute
  typedef struct packed {
    logic [xlen-1:0]       addr_or_result;
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       src2;
    logic [xlen-1:0]       store_data;
    logic [xlen-1:0]       load_mask;
    logic [7:0]            store_mask;
    logic                  load_en;
    logic                  store_en;
    logic                  is_signed;
    wd_sel_e               wd_sel;
    logic [reg_addr_w-1:0] rd;
    logic                  reg_en;
  } lsu_req_t;

  // decoded access
  typedef struct packed {
    kind_e                 kind;
    size_e                 size;
    logic                  is_signed;
    logic [xlen-1:0]       addr;
    logic [xlen-1:0]       store_data;
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       src2;
    wd_sel_e               wd_sel;
    logic [reg_addr_w-1:0] rd;
    logic                  reg_en;
  } access_t;

  // write-back record
  typedef struct packed {
    logic [xlen-1:0]       pc;
    logic [reg_addr_w-1:0] rd;
    logic                  reg_en;
    logic [xlen-1:0]       wd;
  } wb_t;

endpackage

`default_nettype wire

// ==== logic/lsu_result.sv ====
`default_nettype none

module lsu_result
  import lsu_pkg::*;
  import lsu_bus_pkg::*;
(
  input  wire access_t done_i,
  input  wire beat_u   beat_i,
  output wb_t          wb_o
);

  logic [31:0]     lane;
  logic [15:0]     half;
  logic [7:0]      byte_v;
  logic [xlen-1:0] load_data;
  logic [xlen-1:0] wd;

  // word view picks the lane, byte view the byte
  assign lane   = beat_i.words[done_i.addr[2]];
  assign half   = done_i.addr[1] ? lane[31:16] : lane[15:0];
  assign byte_v = beat_i.bytes[done_i.addr[2:0]];

  always_comb begin
    case (done_i.size)
      size_byte: begin
        if (done_i.is_signed) begin
          load_data = {{(xlen - 8){byte_v[7]}}, byte_v};
        end else begin
          load_data = {{(xlen - 8){1'b0}}, byte_v};
        end
      end
      size_half: begin
        if (done_i.is_signed) begin
          load_data = {{(xlen - 16){half[15]}}, half};
        end else begin
          load_data = {{(xlen - 16){1'b0}}, half};
        end
      end
      default: load_data = lane;
    endcase
  end

  always_comb begin
    case (done_i.wd_sel)
      wd_load: wd = load_data;
      wd_link: wd = done_i.pc + 32'd4;
      wd_src2: wd = done_i.src2;
      default: wd = done_i.addr;
    endcase
  end

  // address field carries the alu result
  assign wb_o.pc     = done_i.pc;
  assign wb_o.rd     = done_i.rd;
  assign wb_o.reg_en = done_i.reg_en;
  assign wb_o.wd     = wd;

endmodule

`default_nettype wire

// ==== logic/lsu_store_align.sv ====
`default_nettype none

module lsu_store_align
  import lsu_pkg::*;
  import lsu_bus_pkg::*;
(
  input  wire [addr_w-1:0] addr_i,
  input  wire size_e       size_i,
  input  wire [xlen-1:0]   data_i,
  output logic [beat_w-1:0] wdata_o,
  output logic [strb_w-1:0] wstrb_o
);

  logic [2:0]        offset;
  logic [strb_w-1:0] strb_base;
  logic [beat_w-1:0] data_base;

  always_comb begin
    case (size_i)
      size_byte: begin
        offset    = addr_i[2:0];
        strb_base = {{(strb_w - 1){1'b0}}, 1'b1};
        data_base = {{(beat_w - 8){1'b0}}, data_i[7:0]};
      end
      size_half: begin
        offset    = {addr_i[2:1], 1'b0};
        strb_base = {{(strb_w - 2){1'b0}}, 2'b11};
        data_base = {{(beat_w - 16){1'b0}}, data_i[15:0]};
      end
      default: begin
        offset    = {addr_i[2], 2'b00};
        strb_base = {{(strb_w - 4){1'b0}}, 4'hf};
        data_base = {{(beat_w - xlen){1'b0}}, data_i};
      end
    endcase
  end

  // byte offset moves both strobes and data
  assign wstrb_o = strb_base << offset;
  assign wdata_o = data_base << {offset, 3'b000};

endmodule

`default_nettype wire

// ==== logic/lsu_top.sv ====
`default_nettype none

module lsu_top
  import lsu_pkg::*;
  import lsu_bus_pkg::*;
(
  input  wire            clock,
  input  wire            reset,
  input  wire            in_valid_i,
  input  wire lsu_req_t  in_req_i,
  output logic           in_ready_o,
  output rd_req_t        rd_req_o,
  output logic           rready_o,
  input  wire            arready_i,
  input  wire            rvalid_i,
  input  wire beat_u     rdata_i,
  output wr_req_t        wr_req_o,
  input  wire            awready_i,
  input  wire            wready_i,
  output logic           out_valid_o,
  output wb_t            wb_o
);

  access_t acc;
  logic    acc_valid;
  logic    acc_take;
  access_t done;
  beat_u   beat;

  lsu_decode lsu_decode_i (
    .clock       (clock),
    .reset       (reset),
    .in_valid_i  (in_valid_i),
    .in_req_i    (in_req_i),
    .in_ready_o  (in_ready_o),
    .acc_take_i  (acc_take),
    .acc_valid_o (acc_valid),
    .acc_o       (acc)
  );

  lsu_execute lsu_execute_i (
    .clock        (clock),
    .reset        (reset),
    .acc_valid_i  (acc_valid),
    .acc_i        (acc),
    .acc_take_o   (acc_take),
    .rd_req_o     (rd_req_o),
    .rready_o     (rready_o),
    .arready_i    (arready_i),
    .rvalid_i     (rvalid_i),
    .rdata_i      (rdata_i),
    .wr_req_o     (wr_req_o),
    .awready_i    (awready_i),
    .wready_i     (wready_i),
    .done_valid_o (out_valid_o),
    .done_o       (done),
    .beat_o       (beat)
  );

  // write-back record formed without state
  lsu_result lsu_result_i (
    .done_i (done),
    .beat_i (beat),
    .wb_o   (wb_o)
  );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module lsu_tb -o lsu_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/lsu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulator returned status $status"
  exit 1
fi

if echo "$out" | grep -q "Simulation PASSED"; then
  exit 0
fi
exit 1

// ==== vlog.f ====
logic/lsu_bus_pkg.sv
logic/lsu_pkg.sv
logic/lsu_decode.sv
logic/lsu_store_align.sv
logic/lsu_execute.sv
logic/lsu_result.sv
logic/lsu_top.sv
dv/lsu_checker.sv
dv/lsu_tb.sv
